// ==== rtl/streamer_params.svh ====
/* Streamer parameters
   Widths and FIFO depths shared by the package and the RTL */
`ifndef STREAMER_PARAMS_SVH
`define STREAMER_PARAMS_SVH

// Word address width of the memory port
`define STREAMER_ADDR_W 16

// Memory word and stream word width, two elements per word
`define STREAMER_DATA_W 32

// Transfer length in words
`define STREAMER_LEN_W 8

// Response FIFO depth for each load stream
`define STREAMER_LOAD_FIFO_DEPTH 4

// Write buffer depth on the store side
`define STREAMER_STORE_FIFO_DEPTH 2

`endif

// ==== rtl/streamer_pkg.sv ====
/* Streamer package
   Vector types, enums and bus structs of the matrix-engine streamer */
`include "streamer_params.svh"

package streamer_pkg;

  // Vectors with a meaning of their own
  typedef logic [`STREAMER_ADDR_W-1:0]     addr_t;
  typedef logic [`STREAMER_DATA_W-1:0]     word_t;
  typedef logic [`STREAMER_LEN_W-1:0]      len_t;
  typedef logic [`STREAMER_DATA_W/2-1:0]   half_t;
  typedef logic [`STREAMER_DATA_W/8-1:0]   byte_en_t;
  // Load stream tag, X is 0 and W is 1
  typedef logic                            src_id_t;

  // Element format in memory
  typedef enum logic {
    FMT_FP16,
    FMT_FP8
  } cast_fmt_e;

  typedef enum logic {
    CH_IDLE,
    CH_RUN
  } chan_state_e;

  // Memory request, wen high means read
  typedef struct packed {
    logic     req;
    logic     wen;
    addr_t    add;
    word_t    data;
    byte_en_t be;
    src_id_t  id;
  } mem_req_t;

  // Memory response, r_id echoes the request id
  typedef struct packed {
    logic    gnt;
    logic    r_valid;
    word_t   r_data;
    src_id_t r_id;
  } mem_rsp_t;

  // Forward half of a stream, ready is a port of its own
  typedef struct packed {
    logic  valid;
    word_t data;
  } stream_t;

  typedef struct packed {
    logic      start;
    addr_t     x_base;
    addr_t     w_base;
    addr_t     z_base;
    len_t      len;
    cast_fmt_e fmt;
  } streamer_ctrl_t;

  // Done flags are single-cycle pulses, busy is a level
  typedef struct packed {
    logic x_done;
    logic w_done;
    logic z_done;
    logic busy;
  } streamer_flags_t;

endpackage : streamer_pkg

// ==== rtl/streamer_load.sv ====
/* Streamer load channel
   Reads the X and W operands from memory, buffers them per stream and widens FP8 */
`include "streamer_params.svh"

module streamer_load
  import streamer_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = `STREAMER_LOAD_FIFO_DEPTH
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      start_i,
  input  addr_t     x_base_i,
  input  addr_t     w_base_i,
  input  len_t      len_i,
  input  cast_fmt_e fmt_i,
  output mem_req_t  mem_req_o,
  input  logic      mem_gnt_i,
  input  mem_rsp_t  mem_rsp_i,
  output stream_t   x_stream_o,
  output stream_t   w_stream_o,
  input  logic      x_ready_i,
  input  logic      w_ready_i,
  output logic      x_done_o,
  output logic      w_done_o
);

  localparam int unsigned NUM_SRC = 2;
  localparam int unsigned CNT_W   = $clog2(FIFO_DEPTH + 1);
  localparam int unsigned PTR_W   = $clog2(FIFO_DEPTH);

  typedef logic [CNT_W-1:0] cnt_t;
  typedef logic [PTR_W-1:0] ptr_t;

  // Setup captured at start
  cast_fmt_e   fmt_q;
  len_t        len_q;
  addr_t       base_q [NUM_SRC];

  // Per stream state, index 0 is X and 1 is W
  chan_state_e state_q    [NUM_SRC];
  len_t        req_cnt_q  [NUM_SRC];
  cnt_t        outst_q    [NUM_SRC];
  cnt_t        fifo_cnt_q [NUM_SRC];
  ptr_t        wr_ptr_q   [NUM_SRC];
  ptr_t        rd_ptr_q   [NUM_SRC];
  word_t       fifo_mem_q [NUM_SRC][FIFO_DEPTH];
  logic        done_q     [NUM_SRC];

  logic        want     [NUM_SRC];
  logic        issue    [NUM_SRC];
  logic        push     [NUM_SRC];
  logic        pop      [NUM_SRC];
  logic        last_pop [NUM_SRC];
  logic        ready    [NUM_SRC];
  stream_t     strm     [NUM_SRC];
  logic        launch;

  // Request slot, alternating between X and W
  src_id_t     rr_q;
  logic        hold_q;
  src_id_t     hold_id_q;
  src_id_t     sel;

  function automatic ptr_t next_ptr(ptr_t p);
    return (p == ptr_t'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign ready[0] = x_ready_i;
  assign ready[1] = w_ready_i;

  // Both streams must have drained before a new transfer
  assign launch = start_i && (state_q[0] == CH_IDLE) && (state_q[1] == CH_IDLE);

  always_comb begin
    word_t head;
    half_t elem_lo;
    half_t elem_hi;
    for (int s = 0; s < NUM_SRC; s++) begin
      head    = fifo_mem_q[s][rd_ptr_q[s]];
      elem_lo = head[15:0];
      // Widening appends a zero byte below each FP8 element
      elem_hi = (fmt_q == FMT_FP8) ? {elem_lo[15:8], 8'h00} : head[31:16];
      if (fmt_q == FMT_FP8)
        elem_lo = {elem_lo[7:0], 8'h00};
      strm[s].valid = (fifo_cnt_q[s] != '0);
      strm[s].data  = {elem_hi, elem_lo};
      pop[s]        = strm[s].valid && ready[s];
      // Last word leaves with nothing left in flight
      last_pop[s] = pop[s] && (req_cnt_q[s] == len_q) && (outst_q[s] == '0) &&
                    (fifo_cnt_q[s] == cnt_t'(1));
      // Credit covers words in flight plus words buffered
      want[s] = (state_q[s] == CH_RUN) && (req_cnt_q[s] < len_q) &&
                ((int'(outst_q[s]) + int'(fifo_cnt_q[s])) < FIFO_DEPTH);
      push[s] = mem_rsp_i.r_valid && (mem_rsp_i.r_id == src_id_t'(s));
    end
  end

  always_comb begin
    // An ungranted request keeps its stream
    if (hold_q)
      sel = hold_id_q;
    else if (want[rr_q])
      sel = rr_q;
    else
      sel = ~rr_q;
    for (int s = 0; s < NUM_SRC; s++)
      issue[s] = mem_gnt_i && want[s] && (sel == src_id_t'(s));
    mem_req_o.req  = want[sel];
    mem_req_o.wen  = 1'b1;
    mem_req_o.add  = base_q[sel] + addr_t'(req_cnt_q[sel]);
    mem_req_o.data = '0;
    mem_req_o.be   = '1;
    mem_req_o.id   = sel;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fmt_q     <= FMT_FP16;
      len_q     <= '0;
      rr_q      <= '0;
      hold_q    <= 1'b0;
      hold_id_q <= '0;
      for (int s = 0; s < NUM_SRC; s++) begin
        base_q[s]     <= '0;
        state_q[s]    <= CH_IDLE;
        req_cnt_q[s]  <= '0;
        outst_q[s]    <= '0;
        fifo_cnt_q[s] <= '0;
        wr_ptr_q[s]   <= '0;
        rd_ptr_q[s]   <= '0;
        done_q[s]     <= 1'b0;
      end
    end else begin
      if (launch) begin
        fmt_q     <= fmt_i;
        len_q     <= len_i;
        base_q[0] <= x_base_i;
        base_q[1] <= w_base_i;
      end
      hold_q    <= mem_req_o.req && !mem_gnt_i;
      hold_id_q <= sel;
      // Loser of this grant goes first next time
      if (mem_req_o.req && mem_gnt_i)
        rr_q <= ~sel;
      for (int s = 0; s < NUM_SRC; s++) begin
        if (launch) begin
          state_q[s]   <= CH_RUN;
          req_cnt_q[s] <= '0;
        end else begin
          if (last_pop[s])
            state_q[s] <= CH_IDLE;
          if (issue[s])
            req_cnt_q[s] <= req_cnt_q[s] + 1'b1;
        end
        outst_q[s]    <= outst_q[s] + cnt_t'(issue[s]) - cnt_t'(push[s]);
        fifo_cnt_q[s] <= fifo_cnt_q[s] + cnt_t'(push[s]) - cnt_t'(pop[s]);
        if (push[s])
          wr_ptr_q[s] <= next_ptr(wr_ptr_q[s]);
        if (pop[s])
          rd_ptr_q[s] <= next_ptr(rd_ptr_q[s]);
        done_q[s] <= last_pop[s];
      end
    end
  end

  // Response storage
  always_ff @(posedge clk_i) begin
    for (int s = 0; s < NUM_SRC; s++)
      if (push[s])
        fifo_mem_q[s][wr_ptr_q[s]] <= mem_rsp_i.r_data;
  end

  assign x_stream_o = strm[0];
  assign w_stream_o = strm[1];
  assign x_done_o   = done_q[0];
  assign w_done_o   = done_q[1];

  for (genvar g = 0; g < NUM_SRC; g++) begin : gen_chk
    // Offered word stays put until the engine takes it
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      strm[g].valid && !ready[g] |=> strm[g].valid && $stable(strm[g].data))
      else $error("load stream %0d dropped or changed a word", g);
    // Credit check keeps memory responses from overrunning the buffer
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      push[g] |-> fifo_cnt_q[g] != cnt_t'(FIFO_DEPTH))
      else $error("load FIFO %0d written while full", g);
  end

endmodule : streamer_load

// ==== rtl/streamer_store.sv ====
/* Streamer store channel
   Takes the Z result stream, narrows to FP8 on demand and writes it to memory */
`include "streamer_params.svh"

module streamer_store
  import streamer_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = `STREAMER_STORE_FIFO_DEPTH
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      start_i,
  input  addr_t     z_base_i,
  input  len_t      len_i,
  input  cast_fmt_e fmt_i,
  input  stream_t   z_stream_i,
  output logic      z_ready_o,
  output mem_req_t  mem_req_o,
  input  logic      mem_gnt_i,
  output logic      z_done_o
);

  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

  typedef logic [CNT_W-1:0] cnt_t;
  typedef logic [PTR_W-1:0] ptr_t;

  chan_state_e state_q;
  cast_fmt_e   fmt_q;
  len_t        len_q;
  addr_t       base_q;
  // Words accepted from Z and writes granted
  len_t        in_cnt_q;
  len_t        wr_cnt_q;
  cnt_t        fifo_cnt_q;
  ptr_t        wr_ptr_q;
  ptr_t        rd_ptr_q;
  word_t       data_mem_q [FIFO_DEPTH];
  byte_en_t    be_mem_q   [FIFO_DEPTH];
  logic        done_q;

  half_t       elem_lo;
  half_t       elem_hi;
  word_t       narrow_data;
  byte_en_t    narrow_be;
  logic        push;
  logic        pop;
  logic        last_wr;

  function automatic ptr_t next_ptr(ptr_t p);
    return (p == ptr_t'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // Accept Z only while running, with room and words still due
  assign z_ready_o = (state_q == CH_RUN) && (in_cnt_q < len_q) &&
                     (fifo_cnt_q != cnt_t'(FIFO_DEPTH));
  assign push      = z_stream_i.valid && z_ready_o;
  assign pop       = mem_req_o.req && mem_gnt_i;
  assign last_wr   = pop && (len_t'(wr_cnt_q + 1'b1) == len_q);

  assign elem_lo = z_stream_i.data[15:0];
  assign elem_hi = z_stream_i.data[31:16];

  always_comb begin
    if (fmt_q == FMT_FP8) begin
      // Top byte of each half, upper half of the word left empty
      narrow_data = {half_t'(0), elem_hi[15:8], elem_lo[15:8]};
      narrow_be   = 4'b0011;
    end else begin
      narrow_data = z_stream_i.data;
      narrow_be   = '1;
    end
  end

  // FIFO head drives the write request
  always_comb begin
    mem_req_o.req  = (fifo_cnt_q != '0);
    mem_req_o.wen  = 1'b0;
    mem_req_o.add  = base_q + addr_t'(wr_cnt_q);
    mem_req_o.data = data_mem_q[rd_ptr_q];
    mem_req_o.be   = be_mem_q[rd_ptr_q];
    mem_req_o.id   = '0;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= CH_IDLE;
      fmt_q      <= FMT_FP16;
      len_q      <= '0;
      base_q     <= '0;
      in_cnt_q   <= '0;
      wr_cnt_q   <= '0;
      fifo_cnt_q <= '0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      done_q     <= 1'b0;
    end else begin
      if (start_i && state_q == CH_IDLE) begin
        state_q  <= CH_RUN;
        fmt_q    <= fmt_i;
        len_q    <= len_i;
        base_q   <= z_base_i;
        in_cnt_q <= '0;
        wr_cnt_q <= '0;
      end else begin
        if (push)
          in_cnt_q <= in_cnt_q + 1'b1;
        // Write address advances on grant
        if (pop)
          wr_cnt_q <= wr_cnt_q + 1'b1;
        if (last_wr)
          state_q <= CH_IDLE;
      end
      fifo_cnt_q <= fifo_cnt_q + cnt_t'(push) - cnt_t'(pop);
      if (push)
        wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop)
        rd_ptr_q <= next_ptr(rd_ptr_q);
      done_q <= last_wr;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      data_mem_q[wr_ptr_q] <= narrow_data;
      be_mem_q[wr_ptr_q]   <= narrow_be;
    end
  end

  assign z_done_o = done_q;

  // Every queued write must touch at least one byte
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_req_o.req |-> mem_req_o.be != '0)
    else $error("store write request with empty byte enables");

endmodule : streamer_store

// ==== rtl/streamer_ldst_mux.sv ====
/* Load/store combiner
   Round-robin merge of the two channels onto one memory port */
module streamer_ldst_mux
  import streamer_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  mem_req_t load_req_i,
  input  mem_req_t store_req_i,
  output logic     load_gnt_o,
  output logic     store_gnt_o,
  output mem_req_t mem_req_o,
  input  mem_rsp_t mem_rsp_i,
  output mem_rsp_t load_rsp_o
);

  // Priority pointer, low means load goes first
  logic prio_q;
  // Winner held while the memory withholds grant
  logic lock_q;
  logic lock_store_q;
  logic store_win;
  logic conflict;

  assign conflict = load_req_i.req && store_req_i.req;

  always_comb begin
    if (lock_q)
      store_win = lock_store_q;
    else
      store_win = store_req_i.req && (!load_req_i.req || prio_q);
  end

  assign mem_req_o = store_win ? store_req_i : load_req_i;

  // Grant goes to the winner only
  assign store_gnt_o = mem_rsp_i.gnt && store_win;
  assign load_gnt_o  = mem_rsp_i.gnt && load_req_i.req && !store_win;

  // Stores get no response, everything returning belongs to load
  always_comb begin
    load_rsp_o     = mem_rsp_i;
    load_rsp_o.gnt = load_gnt_o;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prio_q       <= 1'b0;
      lock_q       <= 1'b0;
      lock_store_q <= 1'b0;
    end else begin
      lock_q       <= mem_req_o.req && !mem_rsp_i.gnt;
      lock_store_q <= store_win;
      // Only a resolved conflict moves the pointer
      if (conflict && mem_rsp_i.gnt)
        prio_q <= !store_win;
    end
  end

  // Channels never see a grant together
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(load_gnt_o && store_gnt_o))
    else $error("load and store granted in the same cycle");

endmodule : streamer_ldst_mux

// ==== rtl/streamer_top.sv ====
/* Streamer top level
   Load and store channels sharing one memory port, plus transfer status */
module streamer_top
  import streamer_pkg::*;
(
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  streamer_ctrl_t  ctrl_i,
  output streamer_flags_t flags_o,
  output stream_t         x_stream_o,
  output stream_t         w_stream_o,
  input  logic            x_ready_i,
  input  logic            w_ready_i,
  input  stream_t         z_stream_i,
  output logic            z_ready_o,
  output mem_req_t        mem_req_o,
  input  mem_rsp_t        mem_rsp_i
);

  mem_req_t load_req;
  mem_req_t store_req;
  mem_rsp_t load_rsp;
  logic     load_gnt;
  logic     store_gnt;
  logic     x_done;
  logic     w_done;
  logic     z_done;

  // Busy tracking, one sticky bit per done pulse
  logic     busy_q;
  logic     seen_x_q;
  logic     seen_w_q;
  logic     seen_z_q;
  logic     all_done;

  streamer_load i_load (
    .clk_i      ( clk_i         ),
    .arst_n_i   ( arst_n_i      ),
    .start_i    ( ctrl_i.start  ),
    .x_base_i   ( ctrl_i.x_base ),
    .w_base_i   ( ctrl_i.w_base ),
    .len_i      ( ctrl_i.len    ),
    .fmt_i      ( ctrl_i.fmt    ),
    .mem_req_o  ( load_req      ),
    .mem_gnt_i  ( load_gnt      ),
    .mem_rsp_i  ( load_rsp      ),
    .x_stream_o ( x_stream_o    ),
    .w_stream_o ( w_stream_o    ),
    .x_ready_i  ( x_ready_i     ),
    .w_ready_i  ( w_ready_i     ),
    .x_done_o   ( x_done        ),
    .w_done_o   ( w_done        )
  );

  streamer_store i_store (
    .clk_i      ( clk_i         ),
    .arst_n_i   ( arst_n_i      ),
    .start_i    ( ctrl_i.start  ),
    .z_base_i   ( ctrl_i.z_base ),
    .len_i      ( ctrl_i.len    ),
    .fmt_i      ( ctrl_i.fmt    ),
    .z_stream_i ( z_stream_i    ),
    .z_ready_o  ( z_ready_o     ),
    .mem_req_o  ( store_req     ),
    .mem_gnt_i  ( store_gnt     ),
    .z_done_o   ( z_done        )
  );

  streamer_ldst_mux i_ldst_mux (
    .clk_i       ( clk_i     ),
    .arst_n_i    ( arst_n_i  ),
    .load_req_i  ( load_req  ),
    .store_req_i ( store_req ),
    .load_gnt_o  ( load_gnt  ),
    .store_gnt_o ( store_gnt ),
    .mem_req_o   ( mem_req_o ),
    .mem_rsp_i   ( mem_rsp_i ),
    .load_rsp_o  ( load_rsp  )
  );

  // Pulses of this cycle count as seen
  assign all_done = (seen_x_q || x_done) && (seen_w_q || w_done) && (seen_z_q || z_done);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q   <= 1'b0;
      seen_x_q <= 1'b0;
      seen_w_q <= 1'b0;
      seen_z_q <= 1'b0;
    end else if (!busy_q) begin
      busy_q   <= ctrl_i.start;
      seen_x_q <= 1'b0;
      seen_w_q <= 1'b0;
      seen_z_q <= 1'b0;
    end else if (all_done) begin
      busy_q <= 1'b0;
    end else begin
      seen_x_q <= seen_x_q || x_done;
      seen_w_q <= seen_w_q || w_done;
      seen_z_q <= seen_z_q || z_done;
    end
  end

  assign flags_o.x_done = x_done;
  assign flags_o.w_done = w_done;
  assign flags_o.z_done = z_done;
  assign flags_o.busy   = busy_q;

endmodule : streamer_top

// ==== sim/tb_mem_model.sv ====
/* Testbench memory model
   256-word memory with random grants, one-cycle read latency and a write log port */
module tb_mem_model
  import streamer_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  mem_req_t mem_req_i,
  output mem_rsp_t mem_rsp_o,
  output logic     wr_valid_o,
  output addr_t    wr_addr_o,
  output word_t    wr_data_o,
  output byte_en_t wr_be_o
);
  timeunit 1ns;
  timeprecision 1ps;

  word_t    mem [256];
  integer   seed = 32'hf54c;
  logic     gnt_en_q;
  logic     rvalid_q;
  word_t    rdata_q;
  src_id_t  rid_q;
  logic [7:0] idx;
  word_t    be_mask;
  logic     accept;

  // Preload, upper half a times 3 and lower half a XOR 5a5a
  initial begin
    int p;
    for (int a = 0; a < 256; a++) begin
      p = a * 3;
      mem[a] = {p[15:0], a[15:0] ^ 16'h5a5a};
    end
  end

  assign idx = mem_req_i.add[7:0];
  assign accept = mem_req_i.req && gnt_en_q;

  always_comb begin
    for (int b = 0; b < 4; b++)
      be_mask[8*b +: 8] = {8{mem_req_i.be[b]}};
    // Grant only when the random enable is up
    mem_rsp_o.gnt     = accept;
    mem_rsp_o.r_valid = rvalid_q;
    mem_rsp_o.r_data  = rdata_q;
    mem_rsp_o.r_id    = rid_q;
  end

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gnt_en_q   <= 1'b0;
      rvalid_q   <= 1'b0;
      rdata_q    <= '0;
      rid_q      <= '0;
      wr_valid_o <= 1'b0;
      wr_addr_o  <= '0;
      wr_data_o  <= '0;
      wr_be_o    <= '0;
    end else begin
      // About three grants in four cycles
      gnt_en_q   <= ($unsigned($random(seed)) % 4) != 0;
      rvalid_q   <= 1'b0;
      wr_valid_o <= 1'b0;
      if (accept && mem_req_i.wen) begin
        rvalid_q <= 1'b1;
        rdata_q  <= mem[idx];
        rid_q    <= mem_req_i.id;
      end else if (accept) begin
        for (int b = 0; b < 4; b++)
          if (mem_req_i.be[b])
            mem[idx][8*b +: 8] <= mem_req_i.data[8*b +: 8];
        // Log entry carries only the enabled bytes
        wr_valid_o <= 1'b1;
        wr_addr_o  <= mem_req_i.add;
        wr_data_o  <= mem_req_i.data & be_mask;
        wr_be_o    <= mem_req_i.be;
      end
    end
  end

endmodule : tb_mem_model

// ==== sim/tb_streamer.sv ====
/* Streamer testbench
   Table-driven load, store, back-pressure and flag checks against a memory model */
module tb_streamer
  import streamer_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_ROWS = 5;

  typedef struct packed {
    cast_fmt_e   fmt;
    addr_t       x_base;
    addr_t       w_base;
    addr_t       z_base;
    len_t        len;
    int unsigned thr;
  } row_t;

  logic            clk;
  logic            arst_n;
  streamer_ctrl_t  ctrl;
  streamer_flags_t flags;
  stream_t         x_stream;
  stream_t         w_stream;
  stream_t         z_stream;
  logic            x_ready;
  logic            w_ready;
  logic            z_ready;
  mem_req_t        mem_req;
  mem_rsp_t        mem_rsp;
  logic            wr_valid;
  addr_t           wr_addr;
  word_t           wr_data;
  byte_en_t        wr_be;

  row_t        rows [NUM_ROWS];
  integer      seed = 32'hf54c;
  int          data_errors = 0;
  int          flag_errors = 0;
  int          cycles = 0;
  int          limit = 0;
  int          z_count = 0;
  int          x_done_cnt;
  int          w_done_cnt;
  int          z_done_cnt;
  // Z words sent and writes seen in the current row
  word_t       z_sent [$];
  addr_t       log_addr [$];
  word_t       log_data [$];
  byte_en_t    log_be [$];

  streamer_top UUT (
    .clk_i      ( clk      ),
    .arst_n_i   ( arst_n   ),
    .ctrl_i     ( ctrl     ),
    .flags_o    ( flags    ),
    .x_stream_o ( x_stream ),
    .w_stream_o ( w_stream ),
    .x_ready_i  ( x_ready  ),
    .w_ready_i  ( w_ready  ),
    .z_stream_i ( z_stream ),
    .z_ready_o  ( z_ready  ),
    .mem_req_o  ( mem_req  ),
    .mem_rsp_i  ( mem_rsp  )
  );

  tb_mem_model i_mem (
    .clk_i      ( clk      ),
    .arst_n_i   ( arst_n   ),
    .mem_req_i  ( mem_req  ),
    .mem_rsp_o  ( mem_rsp  ),
    .wr_valid_o ( wr_valid ),
    .wr_addr_o  ( wr_addr  ),
    .wr_data_o  ( wr_data  ),
    .wr_be_o    ( wr_be    )
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Run limit of 40 cycles per table word plus 200
  always @(posedge clk) begin
    cycles++;
    if (limit != 0 && cycles >= limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("Simulation failed");
      $finish;
    end
  end

  // Done pulses and the memory write log are sampled mid-cycle
  always @(negedge clk) begin
    if (arst_n) begin
      if (flags.x_done)
        x_done_cnt++;
      if (flags.w_done)
        w_done_cnt++;
      if (flags.z_done)
        z_done_cnt++;
      if (wr_valid) begin
        log_addr.push_back(wr_addr);
        log_data.push_back(wr_data);
        log_be.push_back(wr_be);
      end
    end
  end

  task automatic set_row(input int i, input cast_fmt_e f, input int xb, input int wb,
                         input int zb, input int ln, input int unsigned thr);
    rows[i].fmt    = f;
    rows[i].x_base = addr_t'(xb);
    rows[i].w_base = addr_t'(wb);
    rows[i].z_base = addr_t'(zb);
    rows[i].len    = len_t'(ln);
    rows[i].thr    = thr;
  endtask

  // Preload pattern of memory word a widened when FP8
  function automatic word_t expected_load(input int a, input cast_fmt_e f);
    int    p;
    word_t w;
    p = a * 3;
    w = {p[15:0], a[15:0] ^ 16'h5a5a};
    if (f == FMT_FP8)
      w = {w[15:8], 8'h00, w[7:0], 8'h00};
    return w;
  endfunction

  // FP8 keeps the top byte of each FP16 half
  function automatic word_t narrow_word(input word_t w, input cast_fmt_e f);
    if (f == FMT_FP8)
      return {16'h0000, w[31:24], w[15:8]};
    return w;
  endfunction

  function automatic word_t z_word(input int n);
    return word_t'(n) * 32'h0103_0507 + 32'h3c00_b800;
  endfunction

  task automatic consume_stream(input int sel, input row_t row);
    int    k;
    int    base;
    logic  taken;
    word_t got;
    word_t exp;
    string name;
    k = 0;
    if (sel == 0) begin
      base = int'(row.x_base);
      name = "x_stream.data";
    end else begin
      base = int'(row.w_base);
      name = "w_stream.data";
    end
    while (k < int'(row.len)) begin
      @(posedge clk);
      #1;
      // Random throttle on ready
      if (sel == 0)
        x_ready = ($unsigned($random(seed)) % 100) < row.thr;
      else
        w_ready = ($unsigned($random(seed)) % 100) < row.thr;
      @(negedge clk);
      taken = (sel == 0) ? (x_stream.valid && x_ready) : (w_stream.valid && w_ready);
      got   = (sel == 0) ? x_stream.data : w_stream.data;
      if (taken) begin
        exp = expected_load(base + k, row.fmt);
        assert (got == exp) else begin
          data_errors++;
          $display("mismatch %s word %0d: expected %h, got %h", name, k, exp, got);
        end
        k++;
      end
    end
    @(posedge clk);
    #1;
    if (sel == 0)
      x_ready = 1'b0;
    else
      w_ready = 1'b0;
  endtask

  task automatic produce_z(input row_t row);
    int    k;
    word_t w;
    k = 0;
    @(posedge clk);
    #1;
    while (k < int'(row.len)) begin
      // Same word stays on the bus until accepted
      w = z_word(z_count);
      z_stream.valid = 1'b1;
      z_stream.data  = w;
      @(negedge clk);
      if (z_ready) begin
        z_sent.push_back(w);
        z_count++;
        k++;
      end
      @(posedge clk);
      #1;
    end
    z_stream.valid = 1'b0;
  endtask

  task automatic check_writes(input int r, input row_t row);
    int       n;
    addr_t    exp_addr;
    word_t    exp_data;
    byte_en_t exp_be;
    assert (log_addr.size() == int'(row.len)) else begin
      flag_errors++;
      $display("row %0d logged %0d writes instead of %0d", r, log_addr.size(), row.len);
    end
    n = (log_addr.size() < z_sent.size()) ? log_addr.size() : z_sent.size();
    for (int k = 0; k < n; k++) begin
      exp_addr = row.z_base + addr_t'(k);
      exp_data = narrow_word(z_sent[k], row.fmt);
      exp_be   = (row.fmt == FMT_FP8) ? 4'b0011 : 4'b1111;
      assert (log_addr[k] == exp_addr) else begin
        data_errors++;
        $display("mismatch wr_addr write %0d: expected %h, got %h", k, exp_addr, log_addr[k]);
      end
      assert (log_data[k] == exp_data) else begin
        data_errors++;
        $display("mismatch wr_data write %0d: expected %h, got %h", k, exp_data, log_data[k]);
      end
      assert (log_be[k] == exp_be) else begin
        data_errors++;
        $display("mismatch wr_be write %0d: expected %h, got %h", k, exp_be, log_be[k]);
      end
    end
  endtask

  task automatic run_row(input int r, input row_t row);
    int wait_cnt;
    @(posedge clk);
    #1;
    z_sent.delete();
    log_addr.delete();
    log_data.delete();
    log_be.delete();
    x_done_cnt  = 0;
    w_done_cnt  = 0;
    z_done_cnt  = 0;
    ctrl.start  = 1'b1;
    ctrl.x_base = row.x_base;
    ctrl.w_base = row.w_base;
    ctrl.z_base = row.z_base;
    ctrl.len    = row.len;
    ctrl.fmt    = row.fmt;
    @(posedge clk);
    #1;
    ctrl.start = 1'b0;
    @(negedge clk);
    assert (flags.busy) else begin
      flag_errors++;
      $display("busy did not rise after start in row %0d", r);
    end
    fork
      consume_stream(0, row);
      consume_stream(1, row);
      produce_z(row);
    join
    // Last writes and done pulses may still be pending
    wait_cnt = 0;
    while (flags.busy && wait_cnt < 64) begin
      @(negedge clk);
      wait_cnt++;
    end
    assert (!flags.busy) else begin
      flag_errors++;
      $display("busy stayed high in row %0d, a done pulse is missing", r);
    end
    assert (x_done_cnt == 1 && w_done_cnt == 1 && z_done_cnt == 1) else begin
      flag_errors++;
      $display("row %0d done pulses x %0d, w %0d, z %0d, each expected once",
               r, x_done_cnt, w_done_cnt, z_done_cnt);
    end
    assert (!x_stream.valid && !w_stream.valid) else begin
      flag_errors++;
      $display("load stream offers a word beyond the length in row %0d", r);
    end
    check_writes(r, row);
  endtask

  initial begin
    int total;
    arst_n   = 1'b0;
    ctrl     = '0;
    x_ready  = 1'b0;
    w_ready  = 1'b0;
    z_stream = '0;
    // Z regions stay clear of every load region
    set_row(0, FMT_FP16, 'h00, 'h20, 'h80, 8, 100);
    set_row(1, FMT_FP8, 'h10, 'h30, 'ha0, 12, 100);
    set_row(2, FMT_FP16, 'h05, 'h40, 'hc0, 16, 30);
    set_row(3, FMT_FP8, 'h50, 'h60, 'he0, 10, 25);
    set_row(4, FMT_FP16, 'h70, 'h71, 'hf0, 1, 50);
    total = 0;
    for (int r = 0; r < NUM_ROWS; r++)
      total += int'(rows[r].len);
    limit = 40 * total + 200;
    repeat (4) @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(negedge clk);
    assert (!flags.busy && !flags.x_done && !flags.w_done && !flags.z_done &&
            !x_stream.valid && !w_stream.valid && !z_ready && !mem_req.req)
      else begin
        flag_errors++;
        $display("outputs not idle after reset");
      end
    for (int r = 0; r < NUM_ROWS; r++)
      run_row(r, rows[r]);
    $display("errors: %0d data mismatches, %0d flag or protocol errors",
             data_errors, flag_errors);
    if (data_errors + flag_errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule : tb_streamer

// ==== vlog.f ====
+incdir+rtl
rtl/streamer_pkg.sv
rtl/streamer_load.sv
rtl/streamer_store.sv
rtl/streamer_ldst_mux.sv
rtl/streamer_top.sv
sim/tb_mem_model.sv
sim/tb_streamer.sv
